//--- Makefile
# Verilator build and run of the address generator testbench

VERILATOR ?= verilator
TOP       ?= tb_addrgen
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
LINTFLAGS ?= -Wall
PASS_MSG  ?= TESTBENCH PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the simulation output
run: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+rtl
rtl/addrgen_pkg.sv
rtl/addrgen_seq.sv
rtl/burst_planner.sv
rtl/ldst_req_queue.sv
rtl/addrgen_top.sv
test/tb_clock.sv
test/tb_addrgen.sv

//--- rtl/addrgen_config.svh
// Build-time constants of the vector address generator, included by the RTL and the testbench
`ifndef ADDRGEN_CONFIG_SVH
`define ADDRGEN_CONFIG_SVH

// Address and data bus
`define ADDRGEN_ADDR_W 32
`define ADDRGEN_DATA_W 64

// log2 of the bus width in bytes, must agree with ADDRGEN_DATA_W
`define ADDRGEN_DATA_BYTES_LOG 3

// A burst never leaves its 4 KiB page
`define ADDRGEN_PAGE_BITS 12

// Longest INCR burst in beats
`define ADDRGEN_MAX_BEATS 256

// Vector length counter width
`define ADDRGEN_VL_W 16

// Entries in the request queue towards the load and store units
`define ADDRGEN_QUEUE_DEPTH 4

`endif

//--- rtl/addrgen_pkg.sv
// Shared types of the vector address generator, imported by the RTL modules and the testbench
`include "addrgen_config.svh"

package addrgen_pkg;

  typedef logic [`ADDRGEN_ADDR_W-1:0] addr_t;
  typedef logic [`ADDRGEN_VL_W-1:0]   vl_t;

  // Element width, encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Unit-stride and strided loads and stores
  typedef enum logic [1:0] {
    VLE  = 2'd0,
    VSE  = 2'd1,
    VLSE = 2'd2,
    VSSE = 2'd3
  } mem_op_e;

  // Command sequencer states
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    CHECK      = 2'd1,
    WAITING    = 2'd2,
    REQUESTING = 2'd3
  } seq_state_e;

  // One issued request as seen by the load and store units
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;      // Beats minus one
    logic [2:0] size;     // log2 of bytes per beat
    logic       is_load;
  } ldst_req_t;

endpackage

//--- rtl/addrgen_seq.sv
// Command sequencer FSM of the address generator, instantiated once inside addrgen_top
module addrgen_seq (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cmd_valid_i,
  input  addrgen_pkg::mem_op_e cmd_op_i,
  input  addrgen_pkg::addr_t   cmd_addr_i,
  input  addrgen_pkg::vew_e    cmd_vew_i,
  input  logic                 st_pending_i,
  input  logic                 ar_ready_i,
  input  logic                 aw_ready_i,
  input  logic                 done_i,
  input  logic                 q_full_i,
  input  logic                 q_empty_i,
  input  logic                 q_head_is_load_i,
  output logic                 load_o,
  output logic                 step_o,
  output logic                 push_o,
  output logic                 is_load_o,
  output logic                 is_burst_o,
  output logic                 ack_o,
  output logic                 exc_valid_o,
  output logic                 exc_load_o,
  output logic                 exc_store_o
);
  import addrgen_pkg::*;

  seq_state_e state_q;
  seq_state_e state_d;
  logic       is_load_q;
  logic       is_burst_q;
  logic [3:0] elem_mask;
  logic       misaligned;
  logic       ch_ready;
  logic       order_ok;
  logic       issue;

  //////////////////////////////////////////////////
  // Issue conditions
  //////////////////////////////////////////////////

  // Base address must be a multiple of the element size
  assign elem_mask  = (4'd1 << cmd_vew_i) - 4'd1;
  assign misaligned = |({1'b0, cmd_addr_i[2:0]} & elem_mask);

  assign ch_ready = is_load_q ? ar_ready_i : aw_ready_i;

  // Switching direction only once the units have drained the queue
  assign order_ok = q_empty_i || (q_head_is_load_i == is_load_q);

  assign issue  = (state_q == REQUESTING) && ch_ready && !q_full_i && order_ok;
  assign step_o = issue;
  assign push_o = issue;
  assign load_o = (state_q == IDLE) && cmd_valid_i;

  assign is_load_o  = is_load_q;
  assign is_burst_o = is_burst_q;

  assign exc_load_o  = exc_valid_o && is_load_q;
  assign exc_store_o = exc_valid_o && !is_load_q;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    ack_o       = 1'b0;
    exc_valid_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (cmd_valid_i) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        if (misaligned) begin
          // Refused without issuing anything
          ack_o       = 1'b1;
          exc_valid_o = 1'b1;
          state_d     = IDLE;
        end else if (st_pending_i) begin
          state_d = WAITING;
        end else begin
          state_d = REQUESTING;
        end
      end
      WAITING: begin
        if (!st_pending_i) begin
          state_d = REQUESTING;
        end
      end
      REQUESTING: begin
        if (issue && done_i) begin
          ack_o   = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      is_load_q  <= 1'b0;
      is_burst_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load_o) begin
        is_load_q  <= cmd_op_i inside {VLE, VLSE};
        is_burst_q <= cmd_op_i inside {VLE, VSE};
      end
    end
  end

  // The source holds the command until its acknowledge
  a_cmd_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != IDLE) |-> cmd_valid_i);

  // CHECK uses the live fields so they must match the captured command
  a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == CHECK) |-> $stable(cmd_op_i) && $stable(cmd_addr_i) && $stable(cmd_vew_i));

endmodule

//--- rtl/addrgen_top.sv
// Top of the vector address generator, connecting sequencer, planner and request queue
`include "addrgen_config.svh"

module addrgen_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Command
  input  logic                 cmd_valid_i,
  input  addrgen_pkg::mem_op_e cmd_op_i,
  input  addrgen_pkg::addr_t   cmd_addr_i,
  input  addrgen_pkg::vl_t     cmd_vl_i,
  input  addrgen_pkg::addr_t   cmd_stride_i,
  input  addrgen_pkg::vew_e    cmd_vew_i,
  input  logic                 st_pending_i,
  output logic                 ack_o,
  output logic                 exc_valid_o,
  output logic                 exc_load_o,
  output logic                 exc_store_o,
  // Read address channel
  output addrgen_pkg::addr_t   ar_addr_o,
  output logic [7:0]           ar_len_o,
  output logic [2:0]           ar_size_o,
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  // Write address channel
  output addrgen_pkg::addr_t   aw_addr_o,
  output logic [7:0]           aw_len_o,
  output logic [2:0]           aw_size_o,
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  // Load and store units
  output addrgen_pkg::addr_t   ldst_addr_o,
  output logic [7:0]           ldst_len_o,
  output logic [2:0]           ldst_size_o,
  output logic                 ldst_is_load_o,
  output logic                 ldst_valid_o,
  input  logic                 ldu_ready_i,
  input  logic                 stu_ready_i
);
  import addrgen_pkg::*;

  logic       load;
  logic       step;
  logic       push;
  logic       is_load;
  logic       is_burst;
  logic       done;
  logic       q_full;
  logic       q_empty;
  addr_t      req_addr;
  logic [7:0] req_len;
  logic [2:0] req_size;
  ldst_req_t  q_wdata;
  ldst_req_t  q_rdata;

  //////////////////////////////////////////////////
  // Address channels
  //////////////////////////////////////////////////

  assign ar_addr_o  = req_addr;
  assign ar_len_o   = req_len;
  assign ar_size_o  = req_size;
  assign ar_valid_o = step && is_load;

  assign aw_addr_o  = req_addr;
  assign aw_len_o   = req_len;
  assign aw_size_o  = req_size;
  assign aw_valid_o = step && !is_load;

  assign q_wdata = '{addr: req_addr, len: req_len, size: req_size, is_load: is_load};

  assign ldst_addr_o    = q_rdata.addr;
  assign ldst_len_o     = q_rdata.len;
  assign ldst_size_o    = q_rdata.size;
  assign ldst_is_load_o = q_rdata.is_load;
  assign ldst_valid_o   = !q_empty;

  addrgen_seq i_addrgen_seq (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_op_i         (cmd_op_i),
    .cmd_addr_i       (cmd_addr_i),
    .cmd_vew_i        (cmd_vew_i),
    .st_pending_i     (st_pending_i),
    .ar_ready_i       (ar_ready_i),
    .aw_ready_i       (aw_ready_i),
    .done_i           (done),
    .q_full_i         (q_full),
    .q_empty_i        (q_empty),
    .q_head_is_load_i (q_rdata.is_load),
    .load_o           (load),
    .step_o           (step),
    .push_o           (push),
    .is_load_o        (is_load),
    .is_burst_o       (is_burst),
    .ack_o            (ack_o),
    .exc_valid_o      (exc_valid_o),
    .exc_load_o       (exc_load_o),
    .exc_store_o      (exc_store_o)
  );

  burst_planner i_burst_planner (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (load),
    .step_i     (step),
    .is_burst_i (is_burst),
    .addr_i     (cmd_addr_i),
    .vl_i       (cmd_vl_i),
    .stride_i   (cmd_stride_i),
    .vew_i      (cmd_vew_i),
    .req_addr_o (req_addr),
    .req_len_o  (req_len),
    .req_size_o (req_size),
    .done_o     (done)
  );

  ldst_req_queue #(
    .DEPTH (`ADDRGEN_QUEUE_DEPTH)
  ) i_ldst_req_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .data_i      (q_wdata),
    .ldu_ready_i (ldu_ready_i),
    .stu_ready_i (stu_ready_i),
    .data_o      (q_rdata),
    .full_o      (q_full),
    .empty_o     (q_empty)
  );

endmodule

//--- rtl/burst_planner.sv
// Address datapath that splits a command into bursts or strided beats, driven by addrgen_seq
`include "addrgen_config.svh"

module burst_planner (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               load_i,
  input  logic               step_i,
  input  logic               is_burst_i,
  input  addrgen_pkg::addr_t addr_i,
  input  addrgen_pkg::vl_t   vl_i,
  input  addrgen_pkg::addr_t stride_i,
  input  addrgen_pkg::vew_e  vew_i,
  output addrgen_pkg::addr_t req_addr_o,
  output logic [7:0]         req_len_o,
  output logic [2:0]         req_size_o,
  output logic               done_o
);
  import addrgen_pkg::*;

  localparam int unsigned ADDR_W      = `ADDRGEN_ADDR_W;
  localparam int unsigned BUS_BYTES   = `ADDRGEN_DATA_W / 8;
  localparam int unsigned BUS_LOG     = `ADDRGEN_DATA_BYTES_LOG;
  localparam int unsigned PAGE_BITS   = `ADDRGEN_PAGE_BITS;
  localparam int unsigned BURST_BYTES = `ADDRGEN_MAX_BEATS * BUS_BYTES;

  // Last bus-aligned byte of the burst starting at start
  function automatic addr_t burst_end(addr_t start, vl_t rem, vew_e vew);
    addr_t start_al;
    addr_t last_byte;
    addr_t limit_byte;
    addr_t end_byte;
    start_al   = {start[ADDR_W-1:BUS_LOG], {BUS_LOG{1'b0}}};
    last_byte  = start + (addr_t'(rem) << vew) - addr_t'(1);
    limit_byte = start_al + addr_t'(BURST_BYTES - 1);
    end_byte   = (last_byte < limit_byte) ? last_byte : limit_byte;
    end_byte   = end_byte | addr_t'(BUS_BYTES - 1);
    // Clip to the end of the start page
    if (end_byte[ADDR_W-1:PAGE_BITS] != start_al[ADDR_W-1:PAGE_BITS]) begin
      end_byte = {start_al[ADDR_W-1:PAGE_BITS], {PAGE_BITS{1'b1}}};
    end
    return end_byte;
  endfunction

  addr_t                cur_q;
  addr_t                cur_d;
  vl_t                  rem_q;
  vl_t                  rem_d;
  addr_t                end_q;
  addr_t                stride_q;
  vew_e                 vew_q;
  vew_e                 vew_d;
  addr_t                start_al;
  addr_t                consumed;
  logic [PAGE_BITS-1:0] span;
  logic [7:0]           beats_m1;
  logic                 burst_last;

  //////////////////////////////////////////////////
  // Current request
  //////////////////////////////////////////////////

  assign start_al = {cur_q[ADDR_W-1:BUS_LOG], {BUS_LOG{1'b0}}};
  assign span     = end_q[PAGE_BITS-1:0] - start_al[PAGE_BITS-1:0];
  assign beats_m1 = 8'(span >> BUS_LOG);

  // Elements covered by this burst, may overshoot at the tail
  assign consumed   = (end_q + addr_t'(1) - cur_q) >> vew_q;
  assign burst_last = addr_t'(rem_q) <= consumed;

  assign req_addr_o = cur_q;
  assign req_len_o  = is_burst_i ? beats_m1 : 8'd0;
  assign req_size_o = is_burst_i ? 3'(BUS_LOG) : {1'b0, vew_q};
  assign done_o     = is_burst_i ? burst_last : (rem_q == vl_t'(1));

  //////////////////////////////////////////////////
  // Next step
  //////////////////////////////////////////////////

  assign vew_d = load_i ? vew_i : vew_q;

  always_comb begin
    cur_d = cur_q;
    rem_d = rem_q;
    if (load_i) begin
      cur_d = addr_i;
      rem_d = vl_i;
    end else if (step_i) begin
      if (is_burst_i) begin
        // Following bursts start bus aligned
        cur_d = end_q + addr_t'(1);
        rem_d = burst_last ? '0 : rem_q - vl_t'(consumed);
      end else begin
        cur_d = cur_q + stride_q;
        rem_d = rem_q - vl_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q <= '0;
    end else begin
      rem_q <= rem_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_q <= cur_d;
    vew_q <= vew_d;
    end_q <= burst_end(cur_d, rem_d, vew_d);
    if (load_i) begin
      stride_q <= stride_i;
    end
  end

  a_step_rem: assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_i |-> (rem_q != '0));

endmodule

//--- rtl/ldst_req_queue.sv
// FIFO of issued requests, pushed by the sequencer and popped by the load and store units
`include "addrgen_config.svh"

module ldst_req_queue #(
  parameter int unsigned DEPTH = `ADDRGEN_QUEUE_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  addrgen_pkg::ldst_req_t data_i,
  input  logic                   ldu_ready_i,
  input  logic                   stu_ready_i,
  output addrgen_pkg::ldst_req_t data_o,
  output logic                   full_o,
  output logic                   empty_o
);
  import addrgen_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ldst_req_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Either unit takes the head
  assign push = push_i && !full_o;
  assign pop  = (ldu_ready_i || stu_ready_i) && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ldu_ready_i || stu_ready_i) |-> !empty_o);

endmodule

//--- test/tb_addrgen.sv
// Testbench top of the vector address generator, runs directed tests against addrgen_top
`include "addrgen_config.svh"

module tb_addrgen;
  import addrgen_pkg::*;

  localparam int CYCLE_LIMIT = 4000;
  localparam longint unsigned BUS_BYTES   = 64'(`ADDRGEN_DATA_W / 8);
  localparam longint unsigned BURST_BYTES = 64'(`ADDRGEN_MAX_BEATS) * BUS_BYTES;
  localparam longint unsigned PAGE_MASK   = (64'd1 << `ADDRGEN_PAGE_BITS) - 64'd1;

  logic       clk;
  logic       rst_n;
  logic       cmd_valid;
  mem_op_e    cmd_op;
  addr_t      cmd_addr;
  vl_t        cmd_vl;
  addr_t      cmd_stride;
  vew_e       cmd_vew;
  logic       st_pending;
  logic       ack;
  logic       exc_valid;
  logic       exc_load;
  logic       exc_store;
  addr_t      ar_addr;
  logic [7:0] ar_len;
  logic [2:0] ar_size;
  logic       ar_valid;
  logic       ar_ready;
  addr_t      aw_addr;
  logic [7:0] aw_len;
  logic [2:0] aw_size;
  logic       aw_valid;
  logic       aw_ready;
  addr_t      ldst_addr;
  logic [7:0] ldst_len;
  logic [2:0] ldst_size;
  logic       ldst_is_load;
  logic       ldst_valid;
  logic       ldu_ready;
  logic       stu_ready;

  // Expected requests in issue order, and what the monitors saw
  ldst_req_t exp_q[$];
  ldst_req_t ar_got[$];
  ldst_req_t aw_got[$];
  ldst_req_t pop_got[$];
  int        cycles    = 0;
  int        ack_count = 0;
  int        occupancy = 0;
  logic      gaps      = 1'b0;
  logic      pops_on   = 1'b1;

  tb_clock i_tb_clock (
    .clk_o (clk)
  );

  addrgen_top i_addrgen_top (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .cmd_valid_i    (cmd_valid),
    .cmd_op_i       (cmd_op),
    .cmd_addr_i     (cmd_addr),
    .cmd_vl_i       (cmd_vl),
    .cmd_stride_i   (cmd_stride),
    .cmd_vew_i      (cmd_vew),
    .st_pending_i   (st_pending),
    .ack_o          (ack),
    .exc_valid_o    (exc_valid),
    .exc_load_o     (exc_load),
    .exc_store_o    (exc_store),
    .ar_addr_o      (ar_addr),
    .ar_len_o       (ar_len),
    .ar_size_o      (ar_size),
    .ar_valid_o     (ar_valid),
    .ar_ready_i     (ar_ready),
    .aw_addr_o      (aw_addr),
    .aw_len_o       (aw_len),
    .aw_size_o      (aw_size),
    .aw_valid_o     (aw_valid),
    .aw_ready_i     (aw_ready),
    .ldst_addr_o    (ldst_addr),
    .ldst_len_o     (ldst_len),
    .ldst_size_o    (ldst_size),
    .ldst_is_load_o (ldst_is_load),
    .ldst_valid_o   (ldst_valid),
    .ldu_ready_i    (ldu_ready),
    .stu_ready_i    (stu_ready)
  );

  //////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(string msg);
    stop_run($sformatf("ERR %0t: %s", $time, msg));
  endtask

  task automatic compare_req(string what, ldst_req_t got, ldst_req_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf(
        "%s: got addr %h len %0d size %0d load %b, expected addr %h len %0d size %0d load %b",
        what, got.addr, got.len, got.size, got.is_load,
        exp.addr, exp.len, exp.size, exp.is_load));
    end
  endtask

  task automatic compare_exc(string what, logic got_valid, logic got_load, logic got_store,
                             logic exp_valid, logic exp_load, logic exp_store);
    if ({got_valid, got_load, got_store} !== {exp_valid, exp_load, exp_store}) begin
      report_mismatch($sformatf("%s: got exc valid/load/store %b%b%b, expected %b%b%b",
        what, got_valid, got_load, got_store, exp_valid, exp_load, exp_store));
    end
  endtask

  task automatic compare_count(string what, int got, int exp);
    if (got != exp) begin
      report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Expected requests
  //////////////////////////////////////////////////

  function automatic ldst_req_t make_req(addr_t addr, logic [7:0] len, logic [2:0] size,
                                         logic is_load);
    ldst_req_t req;
    req.addr    = addr;
    req.len     = len;
    req.size    = size;
    req.is_load = is_load;
    return req;
  endfunction

  // INCR bursts of at most 256 beats that stay inside the 4 KiB page of their start
  function automatic void expect_bursts(addr_t base, int unsigned vl, vew_e vew,
                                        logic is_load);
    longint unsigned pos;
    longint unsigned left;
    longint unsigned first;
    longint unsigned last;
    longint unsigned taken;
    pos  = 64'(base);
    left = 64'(vl) << vew;
    while (left != 64'd0) begin
      first = pos & ~(BUS_BYTES - 64'd1);
      last  = pos + left - 64'd1;
      if (last > first + BURST_BYTES - 64'd1) begin
        last = first + BURST_BYTES - 64'd1;
      end
      last = last | (BUS_BYTES - 64'd1);
      if (last > (pos | PAGE_MASK)) begin
        last = pos | PAGE_MASK;
      end
      exp_q.push_back(make_req(addr_t'(pos), 8'((last + 64'd1 - first) / BUS_BYTES - 64'd1),
                               3'(`ADDRGEN_DATA_BYTES_LOG), is_load));
      taken = last + 64'd1 - pos;
      left  = (taken >= left) ? 64'd0 : left - taken;
      pos   = last + 64'd1;
    end
  endfunction

  // One single-beat request per element
  function automatic void expect_strided(addr_t base, addr_t stride, int unsigned vl,
                                         vew_e vew, logic is_load);
    for (int unsigned k = 0; k < vl; k++) begin
      exp_q.push_back(make_req(base + addr_t'(k) * stride, 8'd0, {1'b0, vew}, is_load));
    end
  endfunction

  //////////////////////////////////////////////////
  // Monitors, ready drivers and timeout
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      stop_run($sformatf("Timeout: the DUT did not finish the tests within %0d cycles",
                         CYCLE_LIMIT));
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (ar_valid && aw_valid) begin
        stop_run("AR and AW valid were high in the same cycle");
      end
      if ((ar_valid && !ar_ready) || (aw_valid && !aw_ready)) begin
        stop_run("An address valid was raised while its ready was low");
      end
      if (ldst_valid && ((aw_valid && ldst_is_load) || (ar_valid && !ldst_is_load))) begin
        stop_run("A request issued while the queue head had the other direction");
      end
      if (ar_valid) begin
        ar_got.push_back(make_req(ar_addr, ar_len, ar_size, 1'b1));
        occupancy++;
      end
      if (aw_valid) begin
        aw_got.push_back(make_req(aw_addr, aw_len, aw_size, 1'b0));
        occupancy++;
      end
      if (ldst_valid && (ldu_ready || stu_ready)) begin
        pop_got.push_back(make_req(ldst_addr, ldst_len, ldst_size, ldst_is_load));
        occupancy--;
      end
      if (occupancy > `ADDRGEN_QUEUE_DEPTH) begin
        stop_run("The request queue took more entries than its depth");
      end
      if (ack) begin
        ack_count++;
      end
    end
  end

  // Units pop only a valid head of their own direction
  always @(negedge clk) begin
    logic pop_go;
    ar_ready  = gaps ? ($urandom_range(9) < 6) : 1'b1;
    aw_ready  = gaps ? ($urandom_range(9) < 6) : 1'b1;
    pop_go    = pops_on && (gaps ? ($urandom_range(1) == 1) : 1'b1);
    ldu_ready = ldst_valid && ldst_is_load && pop_go;
    stu_ready = ldst_valid && !ldst_is_load && pop_go;
  end

  //////////////////////////////////////////////////
  // Command driving
  //////////////////////////////////////////////////

  task automatic start_cmd(mem_op_e op, addr_t addr, int unsigned vl, addr_t stride,
                           vew_e vew);
    @(negedge clk);
    cmd_valid  = 1'b1;
    cmd_op     = op;
    cmd_addr   = addr;
    cmd_vl     = vl_t'(vl);
    cmd_stride = stride;
    cmd_vew    = vew;
  endtask

  // Command held until the acknowledge pulse
  task automatic wait_ack(output logic e_valid, output logic e_load, output logic e_store);
    do begin
      @(posedge clk);
    end while (!ack);
    e_valid = exc_valid;
    e_load  = exc_load;
    e_store = exc_store;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic run_cmd(mem_op_e op, addr_t addr, int unsigned vl, addr_t stride,
                         vew_e vew);
    logic e_valid;
    logic e_load;
    logic e_store;
    start_cmd(op, addr, vl, stride, vew);
    wait_ack(e_valid, e_load, e_store);
    compare_exc("accepted command", e_valid, e_load, e_store, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic drain_queue();
    while (ldst_valid) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check_results(string name, int acks);
    ldst_req_t exp_ar[$];
    ldst_req_t exp_aw[$];
    foreach (exp_q[i]) begin
      if (exp_q[i].is_load) begin
        exp_ar.push_back(exp_q[i]);
      end else begin
        exp_aw.push_back(exp_q[i]);
      end
    end
    compare_count({name, ": AR requests"}, ar_got.size(), exp_ar.size());
    foreach (ar_got[i]) begin
      compare_req($sformatf("%s: AR %0d", name, i), ar_got[i], exp_ar[i]);
    end
    compare_count({name, ": AW requests"}, aw_got.size(), exp_aw.size());
    foreach (aw_got[i]) begin
      compare_req($sformatf("%s: AW %0d", name, i), aw_got[i], exp_aw[i]);
    end
    compare_count({name, ": queue pops"}, pop_got.size(), exp_q.size());
    foreach (pop_got[i]) begin
      compare_req($sformatf("%s: queue entry %0d", name, i), pop_got[i], exp_q[i]);
    end
    compare_count({name, ": acknowledges"}, ack_count, acks);
    exp_q.delete();
    ar_got.delete();
    aw_got.delete();
    pop_got.delete();
    ack_count = 0;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_unit_load();
    expect_bursts(32'h0000_0104, 37, EW32, 1'b1);
    run_cmd(VLE, 32'h0000_0104, 37, '0, EW32);
    drain_queue();
    check_results("load in page", 1);
    expect_bursts(32'h0000_2003, 100, EW8, 1'b1);
    run_cmd(VLE, 32'h0000_2003, 100, '0, EW8);
    drain_queue();
    check_results("byte load", 1);
  endtask

  task automatic test_split_bursts();
    // Store split at 0x1000
    expect_bursts(32'h0000_0ff0, 64, EW16, 1'b0);
    run_cmd(VSE, 32'h0000_0ff0, 64, '0, EW16);
    drain_queue();
    check_results("store across page", 1);
    // Two full bursts of 256 beats
    expect_bursts(32'h0000_1000, 512, EW64, 1'b1);
    run_cmd(VLE, 32'h0000_1000, 512, '0, EW64);
    drain_queue();
    check_results("long load", 1);
  endtask

  task automatic test_strided();
    expect_strided(32'h0000_3000, 32'h0000_0024, 12, EW32, 1'b1);
    run_cmd(VLSE, 32'h0000_3000, 12, 32'h0000_0024, EW32);
    drain_queue();
    check_results("strided load", 1);
    // Negative stride walks downwards
    expect_strided(32'h0000_4002, 32'hffff_fffa, 10, EW16, 1'b0);
    run_cmd(VSSE, 32'h0000_4002, 10, 32'hffff_fffa, EW16);
    drain_queue();
    check_results("strided store", 1);
  endtask

  task automatic test_misaligned();
    logic e_valid;
    logic e_load;
    logic e_store;
    start_cmd(VLE, 32'h0000_5002, 4, '0, EW32);
    wait_ack(e_valid, e_load, e_store);
    compare_exc("misaligned load", e_valid, e_load, e_store, 1'b1, 1'b1, 1'b0);
    start_cmd(VSSE, 32'h0000_6001, 4, 32'h0000_0002, EW16);
    wait_ack(e_valid, e_load, e_store);
    compare_exc("misaligned store", e_valid, e_load, e_store, 1'b1, 1'b0, 1'b1);
    repeat (4) @(negedge clk);
    check_results("misaligned", 2);
  endtask

  task automatic test_backpressure();
    logic e_valid;
    logic e_load;
    logic e_store;
    // Store held back by a pending scalar store
    expect_bursts(32'h0000_7000, 8, EW64, 1'b0);
    start_cmd(VSE, 32'h0000_7000, 8, '0, EW64);
    st_pending = 1'b1;
    repeat (12) begin
      @(negedge clk);
      if (aw_got.size() != 0) begin
        stop_run("An AW request issued while a scalar store was pending");
      end
    end
    st_pending = 1'b0;
    wait_ack(e_valid, e_load, e_store);
    compare_exc("pending store", e_valid, e_load, e_store, 1'b0, 1'b0, 1'b0);
    drain_queue();
    check_results("pending store", 1);

    // Random ready gaps on the channels and the units
    gaps = 1'b1;
    expect_strided(32'h0000_8000, 32'h0000_0010, 16, EW32, 1'b1);
    run_cmd(VLSE, 32'h0000_8000, 16, 32'h0000_0010, EW32);
    expect_bursts(32'h0000_8fe8, 24, EW16, 1'b0);
    run_cmd(VSE, 32'h0000_8fe8, 24, '0, EW16);
    drain_queue();
    check_results("ready gaps", 2);
    gaps = 1'b0;

    // Loads left in the queue hold back the following store
    pops_on = 1'b0;
    expect_strided(32'h0000_a000, 32'h0000_0040, 3, EW64, 1'b1);
    run_cmd(VLSE, 32'h0000_a000, 3, 32'h0000_0040, EW64);
    expect_bursts(32'h0000_b000, 4, EW64, 1'b0);
    start_cmd(VSE, 32'h0000_b000, 4, '0, EW64);
    repeat (10) begin
      @(negedge clk);
      if (aw_got.size() != 0) begin
        stop_run("An AW request issued before the queued loads drained");
      end
    end
    pops_on = 1'b1;
    wait_ack(e_valid, e_load, e_store);
    compare_exc("store after load", e_valid, e_load, e_store, 1'b0, 1'b0, 1'b0);
    drain_queue();
    check_results("store after load", 2);
  endtask

  initial begin
    void'($urandom(32'ha05f));
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd_op     = VLE;
    cmd_addr   = '0;
    cmd_vl     = '0;
    cmd_stride = '0;
    cmd_vew    = EW8;
    st_pending = 1'b0;
    ar_ready   = 1'b0;
    aw_ready   = 1'b0;
    ldu_ready  = 1'b0;
    stu_ready  = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Quiet outputs after reset
    compare_exc("after reset", exc_valid, exc_load, exc_store, 1'b0, 1'b0, 1'b0);
    compare_count("valids after reset", int'({ack, ar_valid, aw_valid, ldst_valid}), 0);

    test_unit_load();
    test_split_bursts();
    test_strided();
    test_misaligned();
    test_backpressure();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- test/tb_clock.sv
// Free-running clock generator of the testbench, instantiated once by tb_addrgen
module tb_clock (
  output logic clk_o
);
  localparam int unsigned HALF_PERIOD = 2;

  // Period of 4 time units, starting low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD);
      clk_o = ~clk_o;
    end
  end

endmodule
